//--- hdl/dsi_proto_pkg.sv
package dsi_proto_pkg;

    typedef logic [5:0] data_type_t;

    localparam data_type_t DT_VSS   = 6'h01;   // vsync start
    localparam data_type_t DT_HSS   = 6'h21;   // hsync start
    localparam data_type_t DT_PPS24 = 6'h3E;   // packed pixel stream, 24 bpp

    // data_id sits in the low byte, so it is the first byte on the wire
    typedef struct packed {
        logic [7:0]  ecc;
        logic [15:0] word_count;
        logic [7:0]  data_id;
    } pkt_header_t;

    typedef union packed {
        pkt_header_t hdr;
        logic [31:0] data;
    } pkt_word_u;

endpackage

//--- hdl/tx_link_pkg.sv
package tx_link_pkg;

    typedef enum logic [3:0] {
        S_IDLE,
        S_SEND_LP_CMD,
        S_SEND_VSS_VSA,
        S_WAIT_H_BLANK_VSS_VSA,
        S_SEND_HSS_VSA,
        S_WAIT_H_BLANK_VSA,
        S_SEND_HSS_HBP,
        S_WAIT_H_BLANK_HBP,
        S_SEND_HSS_ACT,
        S_WAIT_H_BLANK_ACT_HBP,
        S_SEND_DATA_HEADER,
        S_SEND_DATA,
        S_SEND_DATA_CRC,
        S_WAIT_H_BLANK_ACT_HFP,
        S_SEND_HSS_HFP,
        S_WAIT_H_BLANK_HFP
    } seq_state_t;

    typedef struct packed {
        logic                     lp;       // low-power command
        logic                     half;     // only 2 valid bytes
        dsi_proto_pkg::pkt_word_u payload;
    } stage_entry_t;

    typedef struct packed {
        logic        lp;
        logic [31:0] data;   // byte 0 -> lane 0
    } phy_bus_t;

    localparam int LANES_MAX = 4;

    typedef logic [2:0] lane_count_t;

endpackage

//--- hdl/dsi_ecc.sv
module dsi_ecc (
    input  logic [23:0] header,
    output logic [7:0]  ecc
);

    // header bits covered by each parity bit
    localparam logic [23:0] PARITY_MASK [6] = '{
        24'hF12CB7,
        24'hF2555B,
        24'h749A6D,
        24'hB8E38E,
        24'hDF03F0,
        24'hEFFC00
    };

    always_comb
    begin
        ecc = 8'h00;   // bits 7:6 stay zero
        for (int i = 0; i < 6; i++)
            ecc[i] = ^(header & PARITY_MASK[i]);
    end

endmodule

//--- hdl/dsi_crc16.sv
module dsi_crc16 (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,
    input  logic        update,
    input  logic [31:0] data,
    output logic [15:0] crc
);

    // x^16 + x^12 + x^5 + 1, bit-reversed, bits taken lsb first
    function automatic logic [15:0] fold(input logic [15:0] seed, input logic [31:0] word);
        logic [15:0] acc;
        acc = seed;
        for (int i = 0; i < 32; i++)
            acc = (acc[0] ^ word[i]) ? (acc >> 1) ^ 16'h8408 : acc >> 1;
        return acc;
    endfunction

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            crc <= 16'hFFFF;
        else if (clear)
            crc <= 16'hFFFF;
        else if (update)
            crc <= fold(crc, data);
    end

endmodule

//--- hdl/staging_fifo.sv
module staging_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      write,
    input  tx_link_pkg::stage_entry_t entry,
    input  logic                      read,
    output tx_link_pkg::stage_entry_t head,
    output logic                      empty,
    output logic                      full
);

    localparam int AW = $clog2(FIFO_DEPTH);

    tx_link_pkg::stage_entry_t mem [FIFO_DEPTH];
    logic [AW:0]               wr_ptr;   // extra bit tells full from empty
    logic [AW:0]               rd_ptr;

    always_ff @(posedge clk)
    begin
        if (write)
            mem[wr_ptr[AW-1:0]] <= entry;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (write)
                wr_ptr <= wr_ptr + 1'b1;
            if (read)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign head  = mem[rd_ptr[AW-1:0]];   // show-ahead
    assign empty = wr_ptr == rd_ptr;
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    a_no_overflow:  assert property (@(posedge clk) disable iff (!rst_n) write |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) read |-> !empty);

endmodule

//--- hdl/lane_repacker.sv
module lane_repacker (
    input  logic                              clk,
    input  logic                              rst_n,
    input  tx_link_pkg::stage_entry_t         head,
    input  logic                              empty,
    input  tx_link_pkg::lane_count_t          lanes_number,
    input  logic [tx_link_pkg::LANES_MAX-1:0] phy_full,
    output logic                              read,
    output tx_link_pkg::phy_bus_t             phy,
    output logic [tx_link_pkg::LANES_MAX-1:0] phy_write
);

    logic [63:0]                     shift_reg;   // byte 0 is next out
    logic [3:0]                      byte_cnt;
    logic                            lp_q;
    tx_link_pkg::lane_count_t        lanes;
    logic                            out_write;
    logic [3:0]                      out_n;
    logic [3:0]                      keep_n;
    logic [3:0]                      in_n;
    logic [tx_link_pkg::LANES_MAX:0] strobes;

    assign lanes     = lp_q ? 3'd1 : lanes_number;   // LP commands on lane 0 only
    assign out_write = ~|phy_full && (byte_cnt >= 4'(lanes) || (byte_cnt != 4'd0 && empty));
    assign out_n     = (byte_cnt >= 4'(lanes)) ? 4'(lanes) : byte_cnt;
    assign keep_n    = out_write ? byte_cnt - out_n : byte_cnt;
    assign in_n      = head.half ? 4'd2 : 4'd4;
    assign read      = !empty && keep_n <= 4'd4;   // room for a whole word

    assign strobes   = ({{tx_link_pkg::LANES_MAX{1'b0}}, 1'b1} << out_n) - 1'b1;
    assign phy_write = out_write ? strobes[tx_link_pkg::LANES_MAX-1:0] : '0;
    assign phy       = '{lp: lp_q, data: shift_reg[31:0]};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shift_reg <= 64'h0;
            byte_cnt  <= 4'd0;
            lp_q      <= 1'b0;
        end
        else
        begin
            shift_reg <= (out_write ? shift_reg >> (8 * out_n) : shift_reg)
                       | (read ? {32'h0, head.payload.data} << (8 * keep_n) : 64'h0);
            byte_cnt  <= keep_n + (read ? in_n : 4'd0);
            if (read)
                lp_q <= head.lp;
        end
    end

    a_byte_cnt_max: assert property (@(posedge clk) disable iff (!rst_n) byte_cnt <= 4'd8);

endmodule

//--- hdl/frame_sequencer.sv
module frame_sequencer #(
    parameter int BLANK_TIME         = 100,
    parameter int BLANK_TIME_HBP_ACT = 100,
    parameter int VSA_LINES          = 4,
    parameter int HBP_LINES          = 20,
    parameter int ACT_LINES          = 480,
    parameter int HFP_LINES          = 10
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    enable,
    input  logic                    fifo_line_ready,
    input  logic                    send_cmd,
    input  logic                    step,
    input  logic                    line_done,
    output tx_link_pkg::seq_state_t state,
    output logic                    pix_buffer_underflow_set
);

    tx_link_pkg::seq_state_t state_next;
    logic                    send_cmd_q;
    logic                    cmd_edge;
    logic [15:0]             blank_cnt;
    logic                    blank_done;
    logic [15:0]             line_cnt;
    logic                    last_line;
    logic                    line_wait;     // wait that closes a line
    logic [15:0]             phase_lines;   // lines of the phase entered next

    assign cmd_edge   = send_cmd & ~send_cmd_q;
    assign blank_done = blank_cnt == 16'd0;
    assign last_line  = line_cnt == 16'd1;

    assign pix_buffer_underflow_set = (state == tx_link_pkg::S_SEND_DATA_HEADER) && !fifo_line_ready;

    always_comb
    begin
        state_next = state;
        unique case (state)
            tx_link_pkg::S_IDLE:
                if (enable && fifo_line_ready)
                    state_next = tx_link_pkg::S_SEND_VSS_VSA;
                else if (cmd_edge)
                    state_next = tx_link_pkg::S_SEND_LP_CMD;
            tx_link_pkg::S_SEND_LP_CMD:
                state_next = step ? tx_link_pkg::S_IDLE : state;
            tx_link_pkg::S_SEND_VSS_VSA:
                state_next = step ? tx_link_pkg::S_WAIT_H_BLANK_VSS_VSA : state;
            tx_link_pkg::S_WAIT_H_BLANK_VSS_VSA:
                state_next = blank_done ? tx_link_pkg::S_SEND_HSS_VSA : state;
            tx_link_pkg::S_SEND_HSS_VSA:
                state_next = step ? tx_link_pkg::S_WAIT_H_BLANK_VSA : state;
            tx_link_pkg::S_WAIT_H_BLANK_VSA:
                if (blank_done)
                    state_next = last_line ? tx_link_pkg::S_SEND_HSS_HBP
                                           : tx_link_pkg::S_SEND_HSS_VSA;
            tx_link_pkg::S_SEND_HSS_HBP:
                state_next = step ? tx_link_pkg::S_WAIT_H_BLANK_HBP : state;
            tx_link_pkg::S_WAIT_H_BLANK_HBP:
                if (blank_done)
                    state_next = last_line ? tx_link_pkg::S_SEND_HSS_ACT
                                           : tx_link_pkg::S_SEND_HSS_HBP;
            tx_link_pkg::S_SEND_HSS_ACT:
                state_next = step ? tx_link_pkg::S_WAIT_H_BLANK_ACT_HBP : state;
            tx_link_pkg::S_WAIT_H_BLANK_ACT_HBP:
                state_next = blank_done ? tx_link_pkg::S_SEND_DATA_HEADER : state;
            tx_link_pkg::S_SEND_DATA_HEADER:
                state_next = step ? tx_link_pkg::S_SEND_DATA : state;
            tx_link_pkg::S_SEND_DATA:
                state_next = line_done ? tx_link_pkg::S_SEND_DATA_CRC : state;
            tx_link_pkg::S_SEND_DATA_CRC:
                state_next = step ? tx_link_pkg::S_WAIT_H_BLANK_ACT_HFP : state;
            tx_link_pkg::S_WAIT_H_BLANK_ACT_HFP:
                if (blank_done)
                    state_next = last_line ? tx_link_pkg::S_SEND_HSS_HFP
                                           : tx_link_pkg::S_SEND_HSS_ACT;
            tx_link_pkg::S_SEND_HSS_HFP:
                state_next = step ? tx_link_pkg::S_WAIT_H_BLANK_HFP : state;
            tx_link_pkg::S_WAIT_H_BLANK_HFP:
                if (blank_done)
                    state_next = last_line ? tx_link_pkg::S_IDLE : tx_link_pkg::S_SEND_HSS_HFP;
            default:
                state_next = tx_link_pkg::S_IDLE;
        endcase
    end

    always_comb
    begin
        line_wait   = 1'b1;
        phase_lines = 16'd0;
        unique case (state)
            tx_link_pkg::S_WAIT_H_BLANK_VSS_VSA: phase_lines = 16'(VSA_LINES);
            tx_link_pkg::S_WAIT_H_BLANK_VSA:     phase_lines = 16'(HBP_LINES);
            tx_link_pkg::S_WAIT_H_BLANK_HBP:     phase_lines = 16'(ACT_LINES);
            tx_link_pkg::S_WAIT_H_BLANK_ACT_HFP: phase_lines = 16'(HFP_LINES);
            tx_link_pkg::S_WAIT_H_BLANK_HFP:     phase_lines = 16'd0;   // frame ends
            default:                             line_wait   = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= tx_link_pkg::S_IDLE;
            send_cmd_q <= 1'b0;
            blank_cnt  <= 16'd0;
            line_cnt   <= 16'd0;
        end
        else
        begin
            state      <= state_next;
            send_cmd_q <= send_cmd;
            if (state_next != state)
                blank_cnt <= (state_next == tx_link_pkg::S_WAIT_H_BLANK_ACT_HBP)
                           ? 16'(BLANK_TIME_HBP_ACT) : 16'(BLANK_TIME);
            else if (!blank_done)
                blank_cnt <= blank_cnt - 16'd1;
            if (line_wait && blank_done)   // load on phase entry, else one line less
                line_cnt <= (state == tx_link_pkg::S_WAIT_H_BLANK_VSS_VSA || last_line)
                          ? phase_lines : line_cnt - 16'd1;
        end
    end

    a_idle_exit: assert property (@(posedge clk) disable iff (!rst_n)
        $past(state == tx_link_pkg::S_IDLE) && state != tx_link_pkg::S_IDLE
        |-> $past(enable) || $past(cmd_edge));

endmodule

//--- hdl/packet_builder.sv
module packet_builder #(
    parameter int LINE_WIDTH = 640
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  tx_link_pkg::seq_state_t   state,
    input  logic [23:0]               cmd_packet,
    input  logic [31:0]               fifo_data,
    input  logic                      fifo_not_empty,
    input  logic                      fifo_line_ready,
    input  logic                      fifo_full,
    output logic                      fifo_read_ack,
    output logic                      write,
    output tx_link_pkg::stage_entry_t entry,
    output logic                      step,
    output logic                      line_done
);

    localparam logic [15:0] LINE_BYTES = 16'(LINE_WIDTH * 3);       // three bytes per pixel
    localparam logic [15:0] LINE_WORDS = 16'(LINE_WIDTH * 3 / 4);

    logic [7:0]  data_id;
    logic [15:0] word_count;
    logic [7:0]  ecc;
    logic [15:0] crc;
    logic [15:0] words_left;
    logic        want;
    logic        in_header;
    logic        in_data;

    assign in_header = state == tx_link_pkg::S_SEND_DATA_HEADER;
    assign in_data   = state == tx_link_pkg::S_SEND_DATA;

    always_comb
    begin
        data_id    = 8'h00;
        word_count = 16'h0000;
        want       = 1'b1;
        unique case (state)
            tx_link_pkg::S_SEND_LP_CMD:
            begin
                data_id    = cmd_packet[7:0];
                word_count = cmd_packet[23:8];
            end
            tx_link_pkg::S_SEND_VSS_VSA:
                data_id = {2'b00, dsi_proto_pkg::DT_VSS};
            tx_link_pkg::S_SEND_HSS_VSA, tx_link_pkg::S_SEND_HSS_HBP,
            tx_link_pkg::S_SEND_HSS_ACT, tx_link_pkg::S_SEND_HSS_HFP:
                data_id = {2'b00, dsi_proto_pkg::DT_HSS};
            tx_link_pkg::S_SEND_DATA_HEADER:
            begin
                data_id    = {2'b00, dsi_proto_pkg::DT_PPS24};
                word_count = LINE_BYTES;
                want       = fifo_line_ready;   // stall on underflow
            end
            tx_link_pkg::S_SEND_DATA:     want = fifo_not_empty;
            tx_link_pkg::S_SEND_DATA_CRC: want = 1'b1;
            default:                      want = 1'b0;
        endcase
    end

    dsi_ecc u_ecc (
        .header ({word_count, data_id}),
        .ecc    (ecc)
    );

    always_comb
    begin
        entry    = '0;
        entry.lp = state == tx_link_pkg::S_SEND_LP_CMD;
        if (in_data)
            entry.payload.data = fifo_data;
        else if (state == tx_link_pkg::S_SEND_DATA_CRC)
        begin
            entry.half         = 1'b1;
            entry.payload.data = {16'h0000, crc};
        end
        else
            entry.payload.hdr = '{ecc: ecc, word_count: word_count, data_id: data_id};
    end

    assign write         = want && !fifo_full;
    assign step          = write;
    assign fifo_read_ack = write && in_data;
    assign line_done     = fifo_read_ack && words_left == 16'd1;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            words_left <= 16'd0;
        else if (in_header)
            words_left <= LINE_WORDS;
        else if (fifo_read_ack)
            words_left <= words_left - 16'd1;
    end

    dsi_crc16 u_crc (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (in_header),
        .update (fifo_read_ack),
        .data   (fifo_data),
        .crc    (crc)
    );

    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_full |-> !write);

endmodule

//--- hdl/dsi_tx_top.sv
module dsi_tx_top #(
    parameter int LINE_WIDTH         = 640,
    parameter int BLANK_TIME         = 100,
    parameter int BLANK_TIME_HBP_ACT = 100,
    parameter int VSA_LINES          = 4,
    parameter int HBP_LINES          = 20,
    parameter int ACT_LINES          = 480,
    parameter int HFP_LINES          = 10,
    parameter int FIFO_DEPTH         = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [31:0]                         fifo_data,
    input  logic                                fifo_not_empty,
    input  logic                                fifo_line_ready,
    output logic                                fifo_read_ack,
    output tx_link_pkg::phy_bus_t               phy,
    output logic [tx_link_pkg::LANES_MAX-1:0]   phy_write,
    input  logic [tx_link_pkg::LANES_MAX-1:0]   phy_full,
    input  logic                                enable,
    input  logic                                send_cmd,
    input  tx_link_pkg::lane_count_t            lanes_number,
    input  logic [23:0]                         cmd_packet,
    output logic                                pix_buffer_underflow_set
);

    tx_link_pkg::seq_state_t   state;
    tx_link_pkg::stage_entry_t entry;
    tx_link_pkg::stage_entry_t head;
    logic                      step;
    logic                      line_done;
    logic                      write;
    logic                      read;
    logic                      empty;
    logic                      full;

    frame_sequencer #(
        .BLANK_TIME         (BLANK_TIME),
        .BLANK_TIME_HBP_ACT (BLANK_TIME_HBP_ACT),
        .VSA_LINES          (VSA_LINES),
        .HBP_LINES          (HBP_LINES),
        .ACT_LINES          (ACT_LINES),
        .HFP_LINES          (HFP_LINES)
    ) u_sequencer (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .enable                   (enable),
        .fifo_line_ready          (fifo_line_ready),
        .send_cmd                 (send_cmd),
        .step                     (step),
        .line_done                (line_done),
        .state                    (state),
        .pix_buffer_underflow_set (pix_buffer_underflow_set)
    );

    packet_builder #(
        .LINE_WIDTH (LINE_WIDTH)
    ) u_builder (
        .clk             (clk),
        .rst_n           (rst_n),
        .state           (state),
        .cmd_packet      (cmd_packet),
        .fifo_data       (fifo_data),
        .fifo_not_empty  (fifo_not_empty),
        .fifo_line_ready (fifo_line_ready),
        .fifo_full       (full),
        .fifo_read_ack   (fifo_read_ack),
        .write           (write),
        .entry           (entry),
        .step            (step),
        .line_done       (line_done)
    );

    staging_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_staging (
        .clk   (clk),
        .rst_n (rst_n),
        .write (write),
        .entry (entry),
        .read  (read),
        .head  (head),
        .empty (empty),
        .full  (full)
    );

    lane_repacker u_repacker (
        .clk          (clk),
        .rst_n        (rst_n),
        .head         (head),
        .empty        (empty),
        .lanes_number (lanes_number),
        .phy_full     (phy_full),
        .read         (read),
        .phy          (phy),
        .phy_write    (phy_write)
    );

endmodule

//--- bench/dsi_tx_ref_pkg.sv
package dsi_tx_ref_pkg;

    typedef logic [7:0]  byte_q_t [$];
    typedef logic [31:0] word_q_t [$];

    localparam logic [7:0] ID_VSS   = 8'h01;
    localparam logic [7:0] ID_HSS   = 8'h21;
    localparam logic [7:0] ID_PPS24 = 8'h3E;

    // DSI header ECC, one parity equation per bit
    function automatic logic [7:0] header_ecc(input logic [23:0] d);
        logic [7:0] p;
        p    = 8'h00;
        p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13] ^ d[16]
             ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14] ^ d[17]
             ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15] ^ d[18]
             ^ d[20] ^ d[21] ^ d[22];
        p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15] ^ d[19]
             ^ d[20] ^ d[21] ^ d[23];
        p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18] ^ d[19]
             ^ d[20] ^ d[22] ^ d[23];
        p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[18]
             ^ d[19] ^ d[21] ^ d[22] ^ d[23];
        return p;
    endfunction

    // byte-wise reflected CRC-CCITT, low byte of each word first
    function automatic logic [15:0] payload_crc(input word_q_t words);
        logic [15:0] c;
        c = 16'hFFFF;
        foreach (words[w])
        begin
            for (int k = 0; k < 4; k++)
            begin
                c = c ^ {8'h00, words[w][8*k +: 8]};
                for (int i = 0; i < 8; i++)
                    c = c[0] ? (c >> 1) ^ 16'h8408 : c >> 1;
            end
        end
        return c;
    endfunction

    function automatic byte_q_t short_packet(input logic [7:0] id, input logic [15:0] wc);
        byte_q_t q;
        q.push_back(id);
        q.push_back(wc[7:0]);
        q.push_back(wc[15:8]);
        q.push_back(header_ecc({wc, id}));
        return q;
    endfunction

    function automatic byte_q_t frame_stream(input word_q_t words, input int vsa,
                                             input int hbp, input int act, input int hfp,
                                             input int width);
        byte_q_t     q;
        word_q_t     line;
        logic [15:0] crc;
        int          idx;
        idx = 0;
        q   = short_packet(ID_VSS, 16'h0000);
        for (int i = 0; i < vsa + hbp; i++)
            q = {q, short_packet(ID_HSS, 16'h0000)};
        for (int l = 0; l < act; l++)
        begin
            q = {q, short_packet(ID_HSS, 16'h0000)};
            q = {q, short_packet(ID_PPS24, 16'(width * 3))};
            line.delete();
            for (int w = 0; w < width * 3 / 4; w++)
            begin
                line.push_back(words[idx]);
                for (int b = 0; b < 4; b++)
                    q.push_back(words[idx][8*b +: 8]);
                idx++;
            end
            crc = payload_crc(line);
            q.push_back(crc[7:0]);
            q.push_back(crc[15:8]);
        end
        for (int i = 0; i < hfp; i++)
            q = {q, short_packet(ID_HSS, 16'h0000)};
        return q;
    endfunction

endpackage

//--- bench/tb_dsi_tx.sv
module tb_dsi_tx;

    localparam int LINE_WIDTH   = 8;
    localparam int BLANK_TIME   = 5;
    localparam int BLANK_HBP    = 3;
    localparam int VSA_LINES    = 1;
    localparam int HBP_LINES    = 2;
    localparam int ACT_LINES    = 3;
    localparam int HFP_LINES    = 2;
    localparam int LINE_WORDS   = LINE_WIDTH * 3 / 4;
    localparam int DRAIN        = 2 * BLANK_TIME + 10;   // last HFP wait runs out
    localparam int FRAME_BYTES  = 4 + 4 * (VSA_LINES + HBP_LINES + ACT_LINES + HFP_LINES)
                                + ACT_LINES * (4 + 4 * LINE_WORDS + 2);
    localparam int LINE_SLOTS   = 1 + VSA_LINES + HBP_LINES + 2 * ACT_LINES + HFP_LINES;
    localparam int FRAME_CYCLES = 4 * FRAME_BYTES + LINE_SLOTS * (BLANK_TIME + 4) + DRAIN;
    localparam int WATCHDOG     = 8 * FRAME_CYCLES * 4;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic [31:0]              fifo_data;
    logic                     fifo_not_empty;
    logic                     fifo_line_ready;
    logic                     fifo_read_ack;
    tx_link_pkg::phy_bus_t    phy;
    logic [3:0]               phy_write;
    logic [3:0]               phy_full;
    logic                     enable;
    logic                     send_cmd;
    tx_link_pkg::lane_count_t lanes_number;
    logic [23:0]              cmd_packet;
    logic                     pix_buffer_underflow_set;

    dsi_tx_ref_pkg::byte_q_t exp_q;
    dsi_tx_ref_pkg::word_q_t pix_words;
    int                      pix_idx;
    int                      rx_count;
    int                      ack_count;
    int                      err_cnt;
    int                      test_cnt;
    int                      fail_cnt;
    int                      underflow_cycles;
    bit                      ack_seen;
    bit                      exp_lp;
    bit                      gaps_on;
    bit                      bp_on;

    dsi_tx_top #(
        .LINE_WIDTH         (LINE_WIDTH),
        .BLANK_TIME         (BLANK_TIME),
        .BLANK_TIME_HBP_ACT (BLANK_HBP),
        .VSA_LINES          (VSA_LINES),
        .HBP_LINES          (HBP_LINES),
        .ACT_LINES          (ACT_LINES),
        .HFP_LINES          (HFP_LINES),
        .FIFO_DEPTH         (4)
    ) UUT (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .fifo_data                (fifo_data),
        .fifo_not_empty           (fifo_not_empty),
        .fifo_line_ready          (fifo_line_ready),
        .fifo_read_ack            (fifo_read_ack),
        .phy                      (phy),
        .phy_write                (phy_write),
        .phy_full                 (phy_full),
        .enable                   (enable),
        .send_cmd                 (send_cmd),
        .lanes_number             (lanes_number),
        .cmd_packet               (cmd_packet),
        .pix_buffer_underflow_set (pix_buffer_underflow_set)
    );

    always #2 clk = ~clk;

    // pixel source and PHY back-pressure
    always @(posedge clk)
    begin
        if (ack_seen)
            pix_idx++;
        fifo_data      <= (pix_idx < pix_words.size()) ? pix_words[pix_idx] : 32'h0;
        fifo_not_empty <= gaps_on ? ($urandom_range(3) != 0) : 1'b1;
        phy_full       <= (bp_on && $urandom_range(3) == 0) ? 4'($urandom) : 4'h0;
    end

    // PHY sink, sampled between edges
    always @(negedge clk)
    begin
        ack_seen = rst_n && fifo_read_ack;
        if (rst_n)
        begin
            if (pix_buffer_underflow_set)
                underflow_cycles++;
            if (fifo_read_ack)
                ack_count++;
            assert (!fifo_read_ack || fifo_not_empty)
            else
            begin
                $display("fifo_read_ack pulsed at %0t while fifo_not_empty was low", $time);
                err_cnt++;
            end
            assert (phy_write == 4'h0 || phy_full == 4'h0)
            else
            begin
                $display("lane write %b at %0t while phy_full was %b", phy_write, $time, phy_full);
                err_cnt++;
            end
            assert (!exp_lp || phy_write[3:1] == 3'b000)
            else
            begin
                $display("LP command byte left on a lane other than 0 at %0t", $time);
                err_cnt++;
            end
            for (int i = 0; i < 4; i++)
            begin
                if (phy_write[i])
                begin
                    assert (rx_count < exp_q.size())
                    else
                    begin
                        $display("unexpected byte on lane %0d at %0t after the stream", i, $time);
                        err_cnt++;
                    end
                    if (rx_count < exp_q.size())
                    begin
                        assert (phy.data[8*i +: 8] == exp_q[rx_count] && phy.lp == exp_lp)
                        else
                        begin
                            $display("error %0t phy.data lane %0d: got %h lp %b expected %h lp %b",
                                     $time, i, phy.data[8*i +: 8], phy.lp, exp_q[rx_count], exp_lp);
                            err_cnt++;
                        end
                    end
                    rx_count++;
                end
            end
        end
    end

    task automatic report(input string name, input int start_err);
        test_cnt++;
        if (err_cnt == start_err)
            $display("test %s: ok", name);
        else
        begin
            fail_cnt++;
            $display("test %s: %0d errors", name, err_cnt - start_err);
        end
    endtask

    task automatic wait_stream();
        for (int t = 0; t < FRAME_CYCLES && rx_count < exp_q.size(); t++)
            @(posedge clk);
        assert (rx_count >= exp_q.size())
        else
        begin
            $display("stream stopped after %0d of %0d bytes", rx_count, exp_q.size());
            err_cnt++;
        end
        bp_on   = 1'b0;
        gaps_on = 1'b0;
        repeat (DRAIN) @(posedge clk);
    endtask

    task automatic run_frame(input string name, input logic [2:0] lanes, input bit bp,
                             input bit gaps, input bit starve);
        int start_err;
        start_err = err_cnt;
        pix_words.delete();
        for (int i = 0; i < ACT_LINES * LINE_WORDS; i++)
            pix_words.push_back($urandom);
        pix_idx = 0;
        exp_q   = dsi_tx_ref_pkg::frame_stream(pix_words, VSA_LINES, HBP_LINES, ACT_LINES,
                                               HFP_LINES, LINE_WIDTH);
        exp_lp           = 1'b0;
        rx_count         = 0;
        ack_count        = 0;
        underflow_cycles = 0;
        bp_on            = bp;
        gaps_on          = gaps;
        lanes_number    <= lanes;
        enable          <= 1'b1;
        fifo_line_ready <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;   // one pulse starts one frame
        if (starve)
        begin
            fifo_line_ready <= 1'b0;
            for (int t = 0; t < FRAME_CYCLES && underflow_cycles == 0; t++)
                @(posedge clk);
            assert (underflow_cycles != 0)
            else
            begin
                $display("pix_buffer_underflow_set never rose while line ready was low");
                err_cnt++;
            end
            repeat (8) @(posedge clk);
            fifo_line_ready <= 1'b1;
        end
        wait_stream();
        assert (ack_count == ACT_LINES * LINE_WORDS)
        else
        begin
            $display("error %0t fifo_read_ack count: got %0d expected %0d",
                     $time, ack_count, ACT_LINES * LINE_WORDS);
            err_cnt++;
        end
        if (starve)
        begin
            assert (underflow_cycles >= 8)   // high for the whole stall
            else
            begin
                $display("error %0t pix_buffer_underflow_set cycles: got %0d expected at least 8",
                         $time, underflow_cycles);
                err_cnt++;
            end
        end
        else
        begin
            assert (underflow_cycles == 0)
            else
            begin
                $display("error %0t pix_buffer_underflow_set cycles: got %0d expected 0",
                         $time, underflow_cycles);
                err_cnt++;
            end
        end
        report(name, start_err);
    endtask

    task automatic run_command();
        int          start_err;
        logic [7:0]  id;
        logic [15:0] wc;
        start_err = err_cnt;
        id        = 8'($urandom);
        wc        = 16'($urandom);
        exp_q     = dsi_tx_ref_pkg::short_packet(id, wc);
        exp_lp    = 1'b1;
        rx_count  = 0;
        lanes_number <= 3'd4;   // LP still goes out on lane 0
        cmd_packet   <= {wc, id};
        send_cmd     <= 1'b1;
        @(posedge clk);
        send_cmd <= 1'b0;
        wait_stream();
        report("lp command", start_err);
    endtask

    initial
    begin
        void'($urandom(87961));
        rst_n           = 1'b0;
        fifo_data       = 32'h0;
        fifo_not_empty  = 1'b0;
        fifo_line_ready = 1'b0;
        phy_full        = 4'h0;
        enable          = 1'b0;
        send_cmd        = 1'b0;
        lanes_number    = 3'd4;
        cmd_packet      = 24'h0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        run_frame("frame 4 lanes", 3'd4, 1'b0, 1'b0, 1'b0);
        run_frame("frame 1 lane back-pressure", 3'd1, 1'b1, 1'b0, 1'b0);
        run_frame("frame 2 lanes back-pressure", 3'd2, 1'b1, 1'b0, 1'b0);
        run_frame("frame 3 lanes back-pressure", 3'd3, 1'b1, 1'b0, 1'b0);
        run_command();
        run_frame("line ready underflow", 3'd4, 1'b0, 1'b0, 1'b1);
        run_frame("pixel fifo gaps", 3'd2, 1'b1, 1'b1, 1'b0);
        $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial
    begin
        #(WATCHDOG);
        $display("watchdog ran out at %0t before all tests finished", $time);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- list.f
hdl/dsi_proto_pkg.sv
hdl/tx_link_pkg.sv
hdl/dsi_ecc.sv
hdl/dsi_crc16.sv
hdl/staging_fifo.sv
hdl/lane_repacker.sv
hdl/frame_sequencer.sv
hdl/packet_builder.sv
hdl/dsi_tx_top.sv
bench/dsi_tx_ref_pkg.sv
bench/tb_dsi_tx.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = tb_dsi_tx
FILELIST = list.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)
